// File: fpu_pkg.sv
// shared op codes, rounding modes, fpcsr layout and special values for the fpu units
`default_nettype none

package fpu_pkg;

  // operation select on op_i, one per start strobe
  typedef enum logic [2:0] {
    OP_MUL   = 3'd0,
    OP_I2F   = 3'd1,
    OP_F2I   = 3'd2,
    OP_CMPEQ = 3'd3,
    OP_CMPLT = 3'd4,
    OP_CMPLE = 3'd5
  } fpu_op_e;

  // rounding modes
  localparam logic [1:0] RM_NEAREST = 2'd0;  // nearest, ties to even
  localparam logic [1:0] RM_TO_ZERO = 2'd1;  // truncate
  localparam logic [1:0] RM_TO_INFP = 2'd2;  // toward +inf
  localparam logic [1:0] RM_TO_INFM = 2'd3;  // toward -inf

  // exception flag word
  localparam int FPCSR_WIDTH = 9;
  localparam int FPCSR_OVF   = 0;  // overflow
  localparam int FPCSR_UNF   = 1;  // underflow
  localparam int FPCSR_SNF   = 2;  // signaling nan
  localparam int FPCSR_QNF   = 3;  // quiet nan
  localparam int FPCSR_ZF    = 4;  // zero result
  localparam int FPCSR_IXF   = 5;  // inexact
  localparam int FPCSR_IVF   = 6;  // invalid
  localparam int FPCSR_INF   = 7;  // infinity
  localparam int FPCSR_DZF   = 8;  // divide by zero, no divider here

  // special magnitudes, sign goes on top
  localparam logic [30:0] F32_INF  = 31'h7f80_0000;
  localparam logic [30:0] F32_QNAN = 31'h7fc0_0000;
  localparam logic [30:0] F32_SNAN = 31'h7fbf_ffff;

  localparam int EXP_BIAS = 127;  // single precision bias

endpackage

`default_nettype wire

// File: fpu_mul.sv
// multiply unit; decodes specials and registers the unrounded product for the rounder
`timescale 1ns/1ps
`default_nettype none

module fpu_mul (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush_i,      // drop pending op
  input  logic             adv_i,        // advance pipe
  input  logic             start_i,      // op strobe
  input  fpu_pkg::fpu_op_e op_i,
  input  logic [31:0]      opa_i,
  input  logic [31:0]      opb_i,
  output logic             rdy_o,        // one advanced cycle per op
  output logic             sign_o,
  output logic [9:0]       exp10_o,      // signed biased exponent
  output logic [23:0]      fract24_o,    // hidden one at bit 23
  output logic [1:0]       rs_o,         // round & sticky
  output logic             inv_o,        // inf * 0
  output logic             inf_o,        // an operand is inf
  output logic             snan_o,
  output logic             qnan_o,
  output logic             anan_sign_o   // sign for nan output
);
  import fpu_pkg::*;

  logic [7:0]  a_exp, b_exp;
  logic        a_zero, b_zero;   // denormals count as zero
  logic        a_inf, b_inf;
  logic        a_nan, b_nan;
  logic [23:0] a_sig, b_sig;     // hidden one restored
  logic [47:0] prod;             // full 24x24 product
  logic [9:0]  exp_sum;

  assign a_exp  = opa_i[30:23];
  assign b_exp  = opb_i[30:23];
  assign a_zero = (a_exp == 8'd0);
  assign b_zero = (b_exp == 8'd0);
  assign a_inf  = (a_exp == 8'hff) & (opa_i[22:0] == 23'd0);
  assign b_inf  = (b_exp == 8'hff) & (opb_i[22:0] == 23'd0);
  assign a_nan  = (a_exp == 8'hff) & (opa_i[22:0] != 23'd0);
  assign b_nan  = (b_exp == 8'hff) & (opb_i[22:0] != 23'd0);
  assign a_sig  = a_zero ? 24'd0 : {1'b1, opa_i[22:0]};
  assign b_sig  = b_zero ? 24'd0 : {1'b1, opb_i[22:0]};
  assign prod   = {24'd0, a_sig} * {24'd0, b_sig};

  // goes negative for tiny results so the rounder flushes those
  assign exp_sum = {2'b00, a_exp} + {2'b00, b_exp} - 10'(EXP_BIAS) + {9'd0, prod[47]};

  always_ff @(posedge clk) begin
    if (rst || flush_i) rdy_o <= 1'b0;
    else if (adv_i) rdy_o <= start_i & (op_i == OP_MUL);
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o  <= opa_i[31] ^ opb_i[31];
      exp10_o <= (a_zero | b_zero) ? 10'd0 : exp_sum;  // zero product gives zero exp
      if (prod[47]) begin  // product in [2,4)
        fract24_o <= prod[47:24];
        rs_o      <= {prod[23], |prod[22:0]};
      end else begin
        fract24_o <= prod[46:23];
        rs_o      <= {prod[22], |prod[21:0]};
      end
      inv_o       <= (a_inf & b_zero) | (a_zero & b_inf);
      inf_o       <= a_inf | b_inf;
      snan_o      <= (a_nan & ~opa_i[22]) | (b_nan & ~opb_i[22]);  // msb clear marks snan
      qnan_o      <= (a_nan & opa_i[22]) | (b_nan & opb_i[22]);
      anan_sign_o <= a_nan ? opa_i[31] : opb_i[31];
    end
  end

endmodule

`default_nettype wire

// File: fpu_i2f.sv
// integer-to-float unit; normalizes a signed int32 into sign, exponent and 24-bit fraction
`timescale 1ns/1ps
`default_nettype none

module fpu_i2f (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush_i,
  input  logic             adv_i,
  input  logic             start_i,
  input  fpu_pkg::fpu_op_e op_i,
  input  logic [31:0]      opa_i,      // two's complement integer
  output logic             rdy_o,
  output logic             sign_o,
  output logic [9:0]       exp10_o,
  output logic [23:0]      fract24_o,
  output logic [1:0]       rs_o        // bits shifted out
);
  import fpu_pkg::*;

  logic [31:0] mag;      // absolute value
  logic [4:0]  msb_pos;  // index of leading one
  logic [31:0] norm;     // leading one moved to bit 31

  assign mag = opa_i[31] ? (~opa_i + 32'd1) : opa_i;  // -2^31 stays 0x80000000

  // later hits overwrite so the top one remains
  always_comb begin
    msb_pos = 5'd0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) msb_pos = 5'(i);
    end
  end

  assign norm = mag << (5'd31 - msb_pos);

  always_ff @(posedge clk) begin
    if (rst || flush_i) rdy_o <= 1'b0;
    else if (adv_i) rdy_o <= start_i & (op_i == OP_I2F);
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o    <= opa_i[31];
      exp10_o   <= (mag == 32'd0) ? 10'd0 : 10'(EXP_BIAS) + {5'd0, msb_pos};
      fract24_o <= norm[31:8];                 // zero input leaves zero
      rs_o      <= {norm[7], |norm[6:0]};      // only above 2^24 drops bits
    end
  end

endmodule

`default_nettype wire

// File: fpu_f2i.sv
// float-to-integer unit; aligns the significand to a 32-bit magnitude with round/sticky
`timescale 1ns/1ps
`default_nettype none

module fpu_f2i (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush_i,
  input  logic             adv_i,
  input  logic             start_i,
  input  fpu_pkg::fpu_op_e op_i,
  input  logic [31:0]      opa_i,
  output logic             rdy_o,
  output logic             sign_o,
  output logic [31:0]      int32_o,   // unsigned magnitude
  output logic [1:0]       rs_o,
  output logic             ovf_o,     // out of int32 range or nan
  output logic             snan_o
);
  import fpu_pkg::*;

  logic        a_sign;
  logic [7:0]  a_exp;
  logic [22:0] a_fract;
  logic [5:0]  sh;       // unbiased exp + 9
  logic [63:0] fixed;    // 32.32 fixed point
  logic [31:0] int32;
  logic [1:0]  rs;

  assign a_sign  = opa_i[31];
  assign a_exp   = opa_i[30:23];
  assign a_fract = opa_i[22:0];

  // significand lsb sits at 2^(e-bias-23), so 32 fraction bits need e-bias+9
  assign sh    = 6'(a_exp - 8'(EXP_BIAS - 9));
  assign fixed = {40'd0, 1'b1, a_fract} << sh;

  always_comb begin
    if (a_exp == 8'd0) begin                       // zero and denormals
      int32 = 32'd0;
      rs    = 2'b00;
    end else if (a_exp < 8'(EXP_BIAS - 1)) begin   // below one half
      int32 = 32'd0;
      rs    = 2'b01;
    end else if (a_exp > 8'(EXP_BIAS + 31)) begin  // saturated in rounder
      int32 = 32'd0;
      rs    = 2'b00;
    end else begin
      int32 = fixed[63:32];
      rs    = {fixed[31], |fixed[30:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) rdy_o <= 1'b0;
    else if (adv_i) rdy_o <= start_i & (op_i == OP_F2I);
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o  <= a_sign;
      int32_o <= int32;
      rs_o    <= rs;
      // exp of 31 and up overflows, except exactly -2^31
      ovf_o   <= (a_exp >= 8'(EXP_BIAS + 31)) &
                 ~(a_sign & (a_exp == 8'(EXP_BIAS + 31)) & (a_fract == 23'd0));
      snan_o  <= (a_exp == 8'hff) & (a_fract != 23'd0) & ~a_fract[22];
    end
  end

endmodule

`default_nettype wire

// File: fpu_cmp.sv
// compare unit; ordered eq/lt/le with nan handling, result goes straight to the output stage
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush_i,
  input  logic             adv_i,
  input  logic             start_i,
  input  fpu_pkg::fpu_op_e op_i,
  input  logic [31:0]      opa_i,
  input  logic [31:0]      opb_i,
  output logic             rdy_o,
  output logic             res_o,   // compare true
  output logic             inv_o,
  output logic             inf_o    // an operand is inf
);
  import fpu_pkg::*;

  logic [30:0] a_mag, b_mag;    // denormals read as zero
  logic        a_nan, b_nan;
  logic        any_nan, any_snan;
  logic        eq, lt;
  logic        res;

  assign a_mag   = (opa_i[30:23] == 8'd0) ? 31'd0 : opa_i[30:0];
  assign b_mag   = (opb_i[30:23] == 8'd0) ? 31'd0 : opb_i[30:0];
  assign a_nan   = (opa_i[30:23] == 8'hff) & (opa_i[22:0] != 23'd0);
  assign b_nan   = (opb_i[30:23] == 8'hff) & (opb_i[22:0] != 23'd0);
  assign any_nan  = a_nan | b_nan;
  assign any_snan = (a_nan & ~opa_i[22]) | (b_nan & ~opb_i[22]);

  // +0 == -0
  assign eq = (a_mag == b_mag) & ((opa_i[31] == opb_i[31]) | (a_mag == 31'd0));
  // mixed signs: a negative wins; same sign: magnitude order flips when negative
  assign lt = ~eq & ((opa_i[31] != opb_i[31]) ? opa_i[31] : (opa_i[31] ^ (a_mag < b_mag)));

  always_comb begin
    case (op_i)
      OP_CMPEQ: res = eq;
      OP_CMPLT: res = lt;
      default:  res = lt | eq;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) rdy_o <= 1'b0;
    else if (adv_i) rdy_o <= start_i & (op_i inside {OP_CMPEQ, OP_CMPLT, OP_CMPLE});
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      res_o <= res & ~any_nan;                                  // unordered is false
      inv_o <= (op_i == OP_CMPEQ) ? any_snan : any_nan;         // lt/le signal on qnan too
      inf_o <= (opa_i[30:0] == F32_INF) | (opb_i[30:0] == F32_INF);
    end
  end

endmodule

`default_nettype wire

// File: fpu_rnd.sv
// common rounder; selects the ready unit, rounds, finishes specials and sets fpcsr flags
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush_i,
  input  logic                            adv_i,
  input  logic [1:0]                      rmode_i,          // used live in stage 1
  // mul
  input  logic                            mul_rdy_i,
  input  logic                            mul_sign_i,
  input  logic [9:0]                      mul_exp10_i,
  input  logic [23:0]                     mul_fract24_i,
  input  logic [1:0]                      mul_rs_i,
  input  logic                            mul_inv_i,
  input  logic                            mul_inf_i,
  input  logic                            mul_snan_i,
  input  logic                            mul_qnan_i,
  input  logic                            mul_anan_sign_i,
  // i2f
  input  logic                            i2f_rdy_i,
  input  logic                            i2f_sign_i,
  input  logic [9:0]                      i2f_exp10_i,
  input  logic [23:0]                     i2f_fract24_i,
  input  logic [1:0]                      i2f_rs_i,
  // f2i
  input  logic                            f2i_rdy_i,
  input  logic                            f2i_sign_i,
  input  logic [31:0]                     f2i_int32_i,
  input  logic [1:0]                      f2i_rs_i,
  input  logic                            f2i_ovf_i,
  input  logic                            f2i_snan_i,
  // cmp skips stage 1
  input  logic                            cmp_rdy_i,
  input  logic                            cmp_res_i,
  input  logic                            cmp_inv_i,
  input  logic                            cmp_inf_i,
  output logic [31:0]                     fpu_result_o,
  output logic                            fpu_valid_o,
  output logic                            fpu_cmp_flag_o,
  output logic                            fpu_cmp_valid_o,
  output logic [fpu_pkg::FPCSR_WIDTH-1:0] fpcsr_o
);
  import fpu_pkg::*;

  //////////////////////////////////////////////////
  // stage 1: source select and round increment
  //////////////////////////////////////////////////

  logic        s1t_sign, s1t_inv, s1t_inf, s1t_snan, s1t_qnan, s1t_anan_sign, s1t_f2i;
  logic [9:0]  s1t_exp10;
  logic [31:0] s1t_fract32;   // fraction or int magnitude
  logic [1:0]  s1t_rs;
  logic        s1t_lost, s1t_rnd_up;
  logic        rm_nearest, rm_to_infp, rm_to_infm;

  // one source at a time, order only documents it
  always_comb begin
    s1t_sign      = 1'b0;
    s1t_exp10     = 10'd0;
    s1t_fract32   = 32'd0;
    s1t_rs        = 2'b00;
    s1t_inv       = 1'b0;
    s1t_inf       = 1'b0;
    s1t_snan      = 1'b0;
    s1t_qnan      = 1'b0;
    s1t_anan_sign = 1'b0;
    s1t_f2i       = 1'b0;
    if (mul_rdy_i) begin
      s1t_sign      = mul_sign_i;
      s1t_exp10     = mul_exp10_i;
      s1t_fract32   = {8'd0, mul_fract24_i};
      s1t_rs        = mul_rs_i;
      s1t_inv       = mul_inv_i;
      s1t_inf       = mul_inf_i;
      s1t_snan      = mul_snan_i;
      s1t_qnan      = mul_qnan_i;
      s1t_anan_sign = mul_anan_sign_i;
    end else if (i2f_rdy_i) begin
      s1t_sign      = i2f_sign_i;
      s1t_exp10     = i2f_exp10_i;
      s1t_fract32   = {8'd0, i2f_fract24_i};
      s1t_rs        = i2f_rs_i;
    end else if (f2i_rdy_i) begin
      s1t_sign      = f2i_sign_i;
      s1t_fract32   = f2i_int32_i;
      s1t_rs        = f2i_rs_i;
      s1t_snan      = f2i_snan_i;
      s1t_f2i       = 1'b1;
    end
  end

  assign rm_nearest = (rmode_i == RM_NEAREST);
  assign rm_to_infp = (rmode_i == RM_TO_INFP);
  assign rm_to_infm = (rmode_i == RM_TO_INFM);
  assign s1t_lost   = |s1t_rs;

  // nearest: above half, or exactly half with odd lsb
  assign s1t_rnd_up = (rm_nearest & s1t_rs[1] & (s1t_rs[0] | s1t_fract32[0])) |
                      (rm_to_infp & ~s1t_sign & s1t_lost) |
                      (rm_to_infm & s1t_sign & s1t_lost);

  logic              s1o_ready;
  logic              s1o_sign, s1o_lost, s1o_inv, s1o_inf, s1o_snan, s1o_qnan;
  logic              s1o_anan_sign, s1o_f2i, s1o_f2i_ovf;
  logic signed [9:0] s1o_exp10;
  logic [31:0]       s1o_fract32;   // already rounded

  always_ff @(posedge clk) begin
    if (rst || flush_i) s1o_ready <= 1'b0;
    else if (adv_i) s1o_ready <= mul_rdy_i | i2f_rdy_i | f2i_rdy_i;
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1o_sign      <= s1t_sign;
      s1o_exp10     <= s1t_exp10;
      s1o_fract32   <= s1t_fract32 + {31'd0, s1t_rnd_up};
      s1o_lost      <= s1t_lost;
      s1o_inv       <= s1t_inv;
      s1o_inf       <= s1t_inf;
      s1o_snan      <= s1t_snan;
      s1o_qnan      <= s1t_qnan;
      s1o_anan_sign <= s1t_anan_sign;
      s1o_f2i       <= s1t_f2i;
      s1o_f2i_ovf   <= f2i_ovf_i;
    end
  end

  //////////////////////////////////////////////////
  // stage 2: exponent fix-up, specials, flags
  //////////////////////////////////////////////////

  logic                   s2t_shr;       // rounding carried into bit 24
  logic signed [9:0]      s2t_exp10;
  logic [23:0]            s2t_fract24;
  logic                   s2t_dn, s2t_dn_lost;
  logic                   s2t_i32_inv, s2t_i32_zero;
  logic [31:0]            s2t_i32;
  logic [31:0]            s2t_opc;
  logic                   s2t_ine, s2t_ovf, s2t_inf, s2t_unf, s2t_zer;
  logic [FPCSR_WIDTH-1:0] s2t_fpcsr;

  assign s2t_shr     = s1o_fract32[24];
  assign s2t_exp10   = s1o_exp10 + 10'(s2t_shr);
  assign s2t_fract24 = s2t_shr ? s1o_fract32[24:1] : s1o_fract32[23:0];
  assign s2t_dn      = ~s2t_fract24[23] | (s2t_exp10 < 10'sd1);  // zero or too small
  assign s2t_dn_lost = s1o_lost | (|s2t_fract24);                 // flush drops these

  // int path: positive carry into bit 31 overflows
  assign s2t_i32_inv  = (~s1o_sign & s1o_fract32[31]) | s1o_f2i_ovf;
  assign s2t_i32      = (s1o_fract32 ^ {32{s1o_sign}}) + {31'd0, s1o_sign};
  assign s2t_i32_zero = ~s2t_i32_inv & (s2t_i32 == 32'd0);

  always_comb begin
    s2t_ine = s1o_lost;
    s2t_ovf = 1'b0;
    s2t_inf = 1'b0;
    s2t_unf = 1'b0;
    s2t_zer = 1'b0;
    if (s1o_f2i) begin
      s2t_opc = s2t_i32_inv ? (32'h7fff_ffff ^ {32{s1o_sign}}) : s2t_i32;  // saturate
      s2t_zer = s2t_i32_zero;
      s2t_unf = s2t_i32_zero & s1o_lost;
    end else if (s1o_snan | s1o_qnan) begin
      s2t_opc = {s1o_anan_sign, F32_QNAN};
      s2t_ine = 1'b0;
    end else if (s1o_inv) begin
      s2t_opc = {s1o_sign, F32_SNAN};
      s2t_ine = 1'b0;
    end else if (s1o_inf | (s2t_exp10 > 10'sd254)) begin
      s2t_opc = {s1o_sign, F32_INF};
      s2t_ine = s1o_lost | ~s1o_inf;
      s2t_ovf = ~s1o_inf;                  // only a computed inf overflows
      s2t_inf = 1'b1;
    end else if (s2t_dn) begin
      s2t_opc = {s1o_sign, 31'd0};         // flush to signed zero
      s2t_ine = s2t_dn_lost;
      s2t_unf = s2t_dn_lost;
      s2t_zer = 1'b1;
    end else begin
      s2t_opc = {s1o_sign, s2t_exp10[7:0], s2t_fract24[22:0]};
    end
  end

  // flags from both paths, dzf stays clear
  always_comb begin
    s2t_fpcsr = '0;
    if (s1o_ready) begin
      s2t_fpcsr[FPCSR_OVF] = s2t_ovf;
      s2t_fpcsr[FPCSR_UNF] = s2t_unf;
      s2t_fpcsr[FPCSR_SNF] = s1o_inv | (s1o_snan & s1o_f2i);
      s2t_fpcsr[FPCSR_QNF] = s1o_qnan;
      s2t_fpcsr[FPCSR_ZF]  = s2t_zer;
      s2t_fpcsr[FPCSR_IXF] = s2t_ine;
      s2t_fpcsr[FPCSR_IVF] = s1o_inv | (s2t_i32_inv & s1o_f2i) | s1o_snan;
      s2t_fpcsr[FPCSR_INF] = s2t_inf;
    end
    if (cmp_rdy_i) begin
      s2t_fpcsr[FPCSR_IVF] = s2t_fpcsr[FPCSR_IVF] | cmp_inv_i;
      s2t_fpcsr[FPCSR_INF] = s2t_fpcsr[FPCSR_INF] | cmp_inf_i;
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      fpu_result_o    <= 32'd0;
      fpu_valid_o     <= 1'b0;
      fpu_cmp_flag_o  <= 1'b0;
      fpu_cmp_valid_o <= 1'b0;
      fpcsr_o         <= '0;
    end else if (adv_i) begin
      fpu_result_o    <= s1o_ready ? s2t_opc : 32'd0;
      fpu_valid_o     <= s1o_ready | cmp_rdy_i;
      fpu_cmp_flag_o  <= cmp_rdy_i & cmp_res_i;
      fpu_cmp_valid_o <= cmp_rdy_i;
      fpcsr_o         <= s2t_fpcsr;   // zero on idle cycles
    end
  end

endmodule

`default_nettype wire

// File: fpu_top.sv
// fpu top level; connects mul, i2f, f2i and cmp units to the shared rounder
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            adv_i,      // advance all stages
  input  logic                            flush_i,    // kill everything in flight
  input  logic                            start_i,
  input  fpu_pkg::fpu_op_e                op_i,
  input  logic [1:0]                      rmode_i,
  input  logic [31:0]                     opa_i,
  input  logic [31:0]                     opb_i,
  output logic [31:0]                     result_o,
  output logic                            valid_o,
  output logic                            cmp_flag_o,
  output logic                            cmp_valid_o,
  output logic [fpu_pkg::FPCSR_WIDTH-1:0] fpcsr_o
);

  // unit to rounder hints
  logic        mul_rdy, mul_sign, mul_inv, mul_inf, mul_snan, mul_qnan, mul_anan_sign;
  logic [9:0]  mul_exp10;
  logic [23:0] mul_fract24;
  logic [1:0]  mul_rs;
  logic        i2f_rdy, i2f_sign;
  logic [9:0]  i2f_exp10;
  logic [23:0] i2f_fract24;
  logic [1:0]  i2f_rs;
  logic        f2i_rdy, f2i_sign, f2i_ovf, f2i_snan;
  logic [31:0] f2i_int32;
  logic [1:0]  f2i_rs;
  logic        cmp_rdy, cmp_res, cmp_inv, cmp_inf;

  fpu_mul u_mul (
    .clk, .rst, .flush_i, .adv_i, .start_i, .op_i, .opa_i, .opb_i,
    .rdy_o(mul_rdy), .sign_o(mul_sign), .exp10_o(mul_exp10), .fract24_o(mul_fract24),
    .rs_o(mul_rs), .inv_o(mul_inv), .inf_o(mul_inf), .snan_o(mul_snan),
    .qnan_o(mul_qnan), .anan_sign_o(mul_anan_sign)
  );

  fpu_i2f u_i2f (
    .clk, .rst, .flush_i, .adv_i, .start_i, .op_i, .opa_i,
    .rdy_o(i2f_rdy), .sign_o(i2f_sign), .exp10_o(i2f_exp10), .fract24_o(i2f_fract24),
    .rs_o(i2f_rs)
  );

  fpu_f2i u_f2i (
    .clk, .rst, .flush_i, .adv_i, .start_i, .op_i, .opa_i,
    .rdy_o(f2i_rdy), .sign_o(f2i_sign), .int32_o(f2i_int32), .rs_o(f2i_rs),
    .ovf_o(f2i_ovf), .snan_o(f2i_snan)
  );

  fpu_cmp u_cmp (
    .clk, .rst, .flush_i, .adv_i, .start_i, .op_i, .opa_i, .opb_i,
    .rdy_o(cmp_rdy), .res_o(cmp_res), .inv_o(cmp_inv), .inf_o(cmp_inf)
  );

  fpu_rnd u_rnd (
    .clk, .rst, .flush_i, .adv_i, .rmode_i,
    .mul_rdy_i(mul_rdy), .mul_sign_i(mul_sign), .mul_exp10_i(mul_exp10),
    .mul_fract24_i(mul_fract24), .mul_rs_i(mul_rs), .mul_inv_i(mul_inv),
    .mul_inf_i(mul_inf), .mul_snan_i(mul_snan), .mul_qnan_i(mul_qnan),
    .mul_anan_sign_i(mul_anan_sign),
    .i2f_rdy_i(i2f_rdy), .i2f_sign_i(i2f_sign), .i2f_exp10_i(i2f_exp10),
    .i2f_fract24_i(i2f_fract24), .i2f_rs_i(i2f_rs),
    .f2i_rdy_i(f2i_rdy), .f2i_sign_i(f2i_sign), .f2i_int32_i(f2i_int32),
    .f2i_rs_i(f2i_rs), .f2i_ovf_i(f2i_ovf), .f2i_snan_i(f2i_snan),
    .cmp_rdy_i(cmp_rdy), .cmp_res_i(cmp_res), .cmp_inv_i(cmp_inv), .cmp_inf_i(cmp_inf),
    .fpu_result_o(result_o), .fpu_valid_o(valid_o), .fpu_cmp_flag_o(cmp_flag_o),
    .fpu_cmp_valid_o(cmp_valid_o), .fpcsr_o
  );

endmodule

`default_nettype wire

// File: tb_fpu_asserts.sv
// concurrent checks on rounder strobes and outputs, bound into fpu_rnd below
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_asserts (
  input logic                            clk,
  input logic                            rst,
  input logic                            flush_i,
  input logic                            mul_rdy_i,
  input logic                            i2f_rdy_i,
  input logic                            f2i_rdy_i,
  input logic                            cmp_rdy_i,
  input logic                            valid_i,    // rounder valid out
  input logic [fpu_pkg::FPCSR_WIDTH-1:0] fpcsr_i     // rounder flags out
);

  // flush empties the output register
  flush_kills_valid: assert property (@(posedge clk) disable iff (rst)
    flush_i |=> !valid_i)
    else $error("valid high in the cycle after flush");

  // one op per start, so one source
  single_source: assert property (@(posedge clk) disable iff (rst)
    $onehot0({mul_rdy_i, i2f_rdy_i, f2i_rdy_i, cmp_rdy_i}))
    else $error("more than one unit ready in the same cycle");

  idle_flags_clear: assert property (@(posedge clk) disable iff (rst)
    !valid_i |-> (fpcsr_i == '0))
    else $error("fpcsr nonzero while valid is low");

endmodule

bind fpu_rnd tb_fpu_asserts u_asserts (
  .clk(clk), .rst(rst), .flush_i(flush_i),
  .mul_rdy_i(mul_rdy_i), .i2f_rdy_i(i2f_rdy_i), .f2i_rdy_i(f2i_rdy_i), .cmp_rdy_i(cmp_rdy_i),
  .valid_i(fpu_valid_o), .fpcsr_i(fpcsr_o)
);

`default_nettype wire

// File: tb_fpu.sv
// testbench for fpu_top; replays fpu_patterns.txt through the DUT and checks result and fpcsr
`timescale 1ns/1ps
`default_nettype none

module tb_fpu;
  import fpu_pkg::*;

  localparam int MAX_TESTS = 64;

  logic                   clk;
  logic                   rst;
  logic                   adv_i, flush_i, start_i;
  fpu_op_e                op_i;
  logic [1:0]             rmode_i;
  logic [31:0]            opa_i, opb_i;
  logic [31:0]            result_o;
  logic                   valid_o, cmp_flag_o, cmp_valid_o;
  logic [FPCSR_WIDTH-1:0] fpcsr_o;

  // vector table filled once at time zero
  logic [8*24-1:0]        t_name  [MAX_TESTS];
  fpu_op_e                t_op    [MAX_TESTS];
  logic [1:0]             t_rm    [MAX_TESTS];
  logic [31:0]            t_opa   [MAX_TESTS];
  logic [31:0]            t_opb   [MAX_TESTS];
  logic [31:0]            t_res   [MAX_TESTS];   // 0/1 for compares
  logic [FPCSR_WIDTH-1:0] t_flags [MAX_TESTS];
  logic                   t_burst [MAX_TESTS];   // issue on consecutive cycles
  int                     n_tests, n_pass, n_fail;
  logic                   loaded;

  fpu_top u_fpu_top (
    .clk, .rst, .adv_i, .flush_i, .start_i, .op_i, .rmode_i, .opa_i, .opb_i,
    .result_o, .valid_o, .cmp_flag_o, .cmp_valid_o, .fpcsr_o
  );

  always #5 clk = ~clk;  // 10 ns period

  //////////////////////////////////////////////////
  // vector file
  //////////////////////////////////////////////////

  task automatic load_patterns();
    int                     fd, code, op_v, rm_v, burst_v;
    logic [8*24-1:0]        tok;
    logic [8*128-1:0]       skip;
    logic [31:0]            opa_v, opb_v, res_v;
    logic [FPCSR_WIDTH-1:0] flg_v;
    fd = $fopen("fpu_patterns.txt", "r");
    if (fd == 0) begin
      $display("ERROR cannot open fpu_patterns.txt");
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;                     // end of file
      if (tok[7:0] == "#") begin
        code = $fgets(skip, fd);                // drop rest of comment line
      end else begin
        code = $fscanf(fd, "%d %d %h %h %h %h %d", op_v, rm_v, opa_v, opb_v, res_v, flg_v,
                       burst_v);
        if (code != 7) begin
          $display("ERROR malformed vector line after %0s", tok);
          n_fail++;
          break;
        end
        t_name[n_tests]  = tok;
        t_op[n_tests]    = fpu_op_e'(op_v[2:0]);
        t_rm[n_tests]    = rm_v[1:0];
        t_opa[n_tests]   = opa_v;
        t_opb[n_tests]   = opb_v;
        t_res[n_tests]   = res_v;
        t_flags[n_tests] = flg_v;
        t_burst[n_tests] = (burst_v != 0);
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // issue and check
  //////////////////////////////////////////////////

  // one op per falling edge with rmode left in place for stage 1
  task automatic issue_ops(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      start_i = 1'b1;
      op_i    = t_op[i];
      rmode_i = t_rm[i];
      opa_i   = t_opa[i];
      opb_i   = t_opb[i];
      @(negedge clk);
    end
    start_i = 1'b0;
  endtask

  // results come back in issue order
  task automatic check_results(input int first, input int last);
    int          waited;
    logic        is_cmp;
    logic [31:0] got;
    for (int i = first; i <= last; i++) begin
      waited = 0;
      do begin
        @(negedge clk);                         // outputs settled since posedge
        waited++;
      end while (!valid_o && waited < 5);
      is_cmp = (t_op[i] inside {OP_CMPEQ, OP_CMPLT, OP_CMPLE});
      got    = is_cmp ? {31'd0, cmp_flag_o} : result_o;
      if (!valid_o) begin
        $display("ERROR %0s: no valid output within 5 cycles", t_name[i]);
        n_fail++;
      end else if (cmp_valid_o !== is_cmp) begin
        $display("MISMATCH %0s: expected cmp_valid %b, actual cmp_valid %b",
                 t_name[i], is_cmp, cmp_valid_o);
        n_fail++;
      end else if (got !== t_res[i] || fpcsr_o !== t_flags[i]) begin
        $display("MISMATCH %0s: expected %h flags %h, actual %h flags %h",
                 t_name[i], t_res[i], t_flags[i], got, fpcsr_o);
        n_fail++;
      end else begin
        $display("PASS %0s", t_name[i]);
        n_pass++;
      end
    end
  endtask

  task automatic run_group(input int first, input int last);
    fork
      issue_ops(first, last);
      check_results(first, last);
    join
  endtask

  // two muls in flight and a flush before either reaches the output
  task automatic check_flush();
    logic rose;
    rose    = 1'b0;
    start_i = 1'b1;
    op_i    = OP_MUL;
    opa_i   = 32'h3f80_0000;
    opb_i   = 32'h4000_0000;
    @(negedge clk);
    opa_i   = 32'h4040_0000;
    @(negedge clk);
    start_i = 1'b0;
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    repeat (6) begin
      if (valid_o) rose = 1'b1;
      @(negedge clk);
    end
    if (rose) begin
      $display("ERROR flush_clears_pipe: valid_o went high after flush");
      n_fail++;
    end else begin
      $display("PASS flush_clears_pipe");
      n_pass++;
    end
  endtask

  initial begin
    int i;
    int last;
    clk     = 1'b0;
    rst     = 1'b1;
    adv_i   = 1'b1;   // no back-pressure in this bench
    flush_i = 1'b0;
    start_i = 1'b0;
    op_i    = OP_MUL;
    rmode_i = RM_NEAREST;
    opa_i   = 32'd0;
    opb_i   = 32'd0;
    n_tests = 0;
    n_pass  = 0;
    n_fail  = 0;
    loaded  = 1'b0;
    load_patterns();
    loaded  = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (n_tests == 0) begin
      $display("ERROR no test vectors were loaded");
      n_fail++;
    end
    i = 0;
    while (i < n_tests) begin
      last = i;
      if (t_burst[i]) begin
        while (last + 1 < n_tests && t_burst[last + 1]) last++;
      end
      run_group(i, last);
      i = last + 1;
    end
    check_flush();
    $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog budget scales with vector count
  initial begin
    wait (loaded);
    repeat (n_tests * 10 + 100) @(posedge clk);
    $display("ERROR watchdog expired before all tests finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: fpu_patterns.txt
# name op rmode opa opb result fpcsr burst (values in hex, compare result is 0 or 1)
# op 0 mul 1 i2f 2 f2i 3 eq 4 lt 5 le; rmode 0 nearest 1 zero 2 +inf 3 -inf; burst 1 pipelines
mul_tie_even 0 0 3f800002 3fa00000 3fa00002 020 0
mul_tie_odd 0 0 3f800001 3fc00000 3fc00002 020 0
mul_up_pos 0 2 3f800002 3fa00000 3fa00003 020 0
mul_rz_neg 0 1 bf800002 3fa00000 bfa00002 020 0
mul_up_neg 0 2 bf800002 3fa00000 bfa00002 020 0
mul_down_neg 0 3 bf800002 3fa00000 bfa00003 020 0
mul_overflow 0 0 7f000000 7f000000 7f800000 0a1 0
mul_underflow 0 0 9f800000 1f800000 80000000 032 0
mul_inf_x_zero 0 0 7f800000 00000000 7fbfffff 044 0
mul_qnan 0 0 ffc00000 3f800000 ffc00000 008 0
i2f_zero 1 0 00000000 00000000 00000000 010 0
i2f_neg5 1 0 fffffffb 00000000 c0a00000 000 0
i2f_2p24p1_rne 1 0 01000001 00000000 4b800000 020 0
i2f_2p24p1_up 1 2 01000001 00000000 4b800001 020 0
i2f_2p24p3_rne 1 0 01000003 00000000 4b800002 020 0
f2i_2p5_rne 2 0 40200000 00000000 00000002 020 0
f2i_2p5_up 2 2 40200000 00000000 00000003 020 0
f2i_m2p5_rz 2 1 c0200000 00000000 fffffffe 020 0
f2i_m2p5_down 2 3 c0200000 00000000 fffffffd 020 0
f2i_ovf_sat 2 0 4f800000 00000000 7fffffff 040 0
f2i_min_int 2 0 cf000000 00000000 80000000 000 0
f2i_snan 2 0 7f800001 00000000 7fffffff 044 0
cmp_eq_zeros 3 0 00000000 80000000 00000001 000 0
cmp_lt_zeros 4 0 80000000 00000000 00000000 000 0
cmp_lt_neg 4 0 c0000000 bf800000 00000001 000 0
cmp_le_inf 5 0 7f800000 7f800000 00000001 080 0
cmp_eq_qnan 3 0 7fc00000 7fc00000 00000000 000 0
cmp_lt_qnan 4 0 7fc00000 3f800000 00000000 040 0
cmp_eq_snan 3 0 7f800001 3f800000 00000000 040 0
b2b_mul_6 0 0 40000000 40400000 40c00000 000 1
b2b_mul_m2p25 0 0 bfc00000 3fc00000 c0100000 000 1
b2b_mul_0p25 0 0 3f000000 3f000000 3e800000 000 1

// File: vlog.f
fpu_pkg.sv
fpu_mul.sv
fpu_i2f.sv
fpu_f2i.sv
fpu_cmp.sv
fpu_rnd.sv
fpu_top.sv
tb_fpu_asserts.sv
tb_fpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpu
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
